/* hdl/dmaRegPkg.sv */
package dmaRegPkg;

	// widths and channel count fixed by the register map
	localparam int dataWidth = 8;
	localparam int addrWidth = 16;
	localparam int numChannels = 4;
	// channel index width, taken from A2:A1 on the cpu side
	localparam int chanBits = $clog2(numChannels);

	// command register
	// only controller disable (bit 2) and rotating priority (bit 4) are decoded
	typedef struct packed {
		logic [2:0] reservedHigh;
		logic rotatePriority;
		logic reservedMid;
		logic ctrlDisable;
		logic [1:0] reservedLow;
	} command_s;

	// mode byte as written by the cpu
	// transfer type 00 verify, 01 write to memory, 10 read from memory
	typedef struct packed {
		logic [1:0] modeSel;
		logic addrDec;
		logic autoInit;
		logic [1:0] xferType;
		logic [chanBits-1:0] chanSel;
	} mode_s;

	// one programming byte, seen as command or mode depending on the port
	typedef union packed {
		command_s command;
		mode_s mode;
	} progWord_u;

	// what a channel shows to the rest of the controller
	typedef struct packed {
		logic [addrWidth-1:0] curAddr;
		logic [addrWidth-1:0] curCount;
		logic [1:0] xferType;
		logic tc;
	} chanState_s;

endpackage

/* hdl/dmaBusPkg.sv */
package dmaBusPkg;

	// cpu side inputs, strobes are active low
	typedef struct packed {
		logic csN;
		logic iorN;
		logic iowN;
		logic [3:0] addr;
		logic [dmaRegPkg::dataWidth-1:0] dbIn;
	} cpuBus_s;

	// system bus control outputs driven during a transfer
	typedef struct packed {
		logic iorN;
		logic iowN;
		logic memrN;
		logic memwN;
		logic aen;
		logic adstb;
		logic hrq;
	} busCtrl_s;

	// byte write into a channel register
	// isMode marks a mode byte, otherwise isCount picks count over address
	typedef struct packed {
		logic valid;
		logic isMode;
		logic isCount;
		logic highByte;
		logic [dmaRegPkg::chanBits-1:0] channel;
		logic [dmaRegPkg::dataWidth-1:0] data;
	} regWrite_s;

	// end of one single transfer
	typedef struct packed {
		logic valid;
		logic [dmaRegPkg::chanBits-1:0] channel;
	} xferDone_s;

	// non-channel port addresses
	localparam logic [3:0] portCommand = 4'd8;
	localparam logic [3:0] portMode = 4'd11;
	localparam logic [3:0] portClearFF = 4'd12;

	// transfer timing states, one-hot
	// bit 4 (S3) is spare since READY and wait states are not supported
	typedef enum logic [5:0] {
		SI = 6'b000001,
		S0 = 6'b000010,
		S1 = 6'b000100,
		S2 = 6'b001000,
		S4 = 6'b100000
	} dmaState_e;

endpackage

/* hdl/dmaProgramPort.sv */
`timescale 1ns/1ps

module dmaProgramPort (
	input logic busIf,
	input logic rst,
	input dmaBusPkg::cpuBus_s cpu,
	input logic [dmaRegPkg::numChannels-1:0] dreq,
	input dmaRegPkg::chanState_s [dmaRegPkg::numChannels-1:0] chanState,
	output dmaRegPkg::command_s command,
	output dmaBusPkg::regWrite_s regWrite,
	output logic [dmaRegPkg::dataWidth-1:0] dbOut,
	output logic dbOutEn
);

	// access decode
	logic access;
	logic wrAccess;
	logic rdAccess;
	logic chanPort;
	logic modeWrite;
	logic [dmaRegPkg::chanBits-1:0] accChan;
	// programming byte with its two views
	dmaRegPkg::progWord_u progWord;
	// byte pointer flip-flop, 0 selects the low byte
	logic bytePtr;
	// read path
	logic [dmaRegPkg::addrWidth-1:0] selWord;
	logic [dmaRegPkg::numChannels-1:0] tcFlags;
	logic [dmaRegPkg::dataWidth-1:0] rdByte;
	// bidirectional io data buffer
	logic [dmaRegPkg::dataWidth-1:0] ioDataBuffer;

	// a valid access has chip select and exactly one of the two strobes
	assign access = ~cpu.csN & (cpu.iorN ^ cpu.iowN);
	assign wrAccess = access & ~cpu.iowN;
	assign rdAccess = access & ~cpu.iorN;

	// ports 0 to 7 are channel registers, A0 picks count over address
	assign chanPort = ~cpu.addr[3];
	assign accChan = cpu.addr[2:1];
	assign modeWrite = wrAccess && (cpu.addr == dmaBusPkg::portMode);

	assign progWord = cpu.dbIn;

	// channel register strobe, the mode byte names its own channel
	always_comb
	begin
		regWrite.valid = (wrAccess && chanPort) || modeWrite;
		regWrite.isMode = modeWrite;
		regWrite.isCount = cpu.addr[0];
		regWrite.highByte = bytePtr;
		regWrite.channel = modeWrite ? progWord.mode.chanSel : accChan;
		regWrite.data = cpu.dbIn;
	end

	// command register and byte pointer
	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			command <= '0;
			bytePtr <= 1'b0;
		end
		else
		begin
			if (wrAccess && (cpu.addr == dmaBusPkg::portCommand))
				command <= progWord.command;
			// clear flip-flop port resets the pointer
			// any channel register access flips it
			if (wrAccess && (cpu.addr == dmaBusPkg::portClearFF))
				bytePtr <= 1'b0;
			else if (access && chanPort)
				bytePtr <= ~bytePtr;
		end
	end

	// read selection
	always_comb
	begin
		for (int c = 0; c < dmaRegPkg::numChannels; c++)
		begin
			tcFlags[c] = chanState[c].tc;
		end
		selWord = cpu.addr[0] ? chanState[accChan].curCount : chanState[accChan].curAddr;
		rdByte = '0;
		if (chanPort)
			rdByte = bytePtr ? selWord[dmaRegPkg::addrWidth-1:dmaRegPkg::dataWidth] :
				selWord[dmaRegPkg::dataWidth-1:0];
		else if (cpu.addr == dmaBusPkg::portCommand)
			// status: raw requests above, terminal counts below
			rdByte = {dreq, tcFlags};
	end

	// data buffer takes the cpu byte on writes and the register byte on reads
	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			ioDataBuffer <= '0;
			dbOutEn <= 1'b0;
		end
		else
		begin
			if (wrAccess)
				ioDataBuffer <= cpu.dbIn;
			else if (rdAccess)
				ioDataBuffer <= rdByte;
			// drive the bus only in the cycle after the read
			dbOutEn <= rdAccess;
		end
	end

	assign dbOut = ioDataBuffer;

endmodule

/* hdl/dmaChannelRegs.sv */
`timescale 1ns/1ps

module dmaChannelRegs (
	input logic busIf,
	input logic rst,
	input dmaBusPkg::regWrite_s regWrite,
	input dmaBusPkg::xferDone_s xferDone,
	output dmaRegPkg::chanState_s [dmaRegPkg::numChannels-1:0] chanState
);

	// per-channel registers
	logic [dmaRegPkg::addrWidth-1:0] baseAddr [dmaRegPkg::numChannels];
	logic [dmaRegPkg::addrWidth-1:0] baseCount [dmaRegPkg::numChannels];
	logic [dmaRegPkg::addrWidth-1:0] curAddr [dmaRegPkg::numChannels];
	logic [dmaRegPkg::addrWidth-1:0] curCount [dmaRegPkg::numChannels];
	logic [1:0] xferType [dmaRegPkg::numChannels];
	logic [dmaRegPkg::numChannels-1:0] addrDec;
	logic [dmaRegPkg::numChannels-1:0] tc;
	// per-channel load and step enables
	logic [dmaRegPkg::numChannels-1:0] addrLoad;
	logic [dmaRegPkg::numChannels-1:0] countLoad;
	logic [dmaRegPkg::numChannels-1:0] modeLoad;
	logic [dmaRegPkg::numChannels-1:0] step;
	// targeted base word merged with the incoming byte
	logic [dmaRegPkg::addrWidth-1:0] oldBase;
	logic [dmaRegPkg::addrWidth-1:0] newBase;
	dmaRegPkg::mode_s modeByte;

	assign modeByte = regWrite.data;

	always_comb
	begin
		oldBase = regWrite.isCount ? baseCount[regWrite.channel] : baseAddr[regWrite.channel];
		newBase = regWrite.highByte ? {regWrite.data, oldBase[dmaRegPkg::dataWidth-1:0]} :
			{oldBase[dmaRegPkg::addrWidth-1:dmaRegPkg::dataWidth], regWrite.data};
		for (int c = 0; c < dmaRegPkg::numChannels; c++)
		begin
			addrLoad[c] = regWrite.valid && !regWrite.isMode && !regWrite.isCount &&
				(regWrite.channel == c);
			countLoad[c] = regWrite.valid && !regWrite.isMode && regWrite.isCount &&
				(regWrite.channel == c);
			modeLoad[c] = regWrite.valid && regWrite.isMode && (regWrite.channel == c);
			step[c] = xferDone.valid && (xferDone.channel == c);
		end
	end

	always_ff @(posedge busIf)
	begin
		for (int c = 0; c < dmaRegPkg::numChannels; c++)
		begin
			if (rst)
			begin
				baseAddr[c] <= '0;
				baseCount[c] <= '0;
				curAddr[c] <= '0;
				curCount[c] <= '0;
				xferType[c] <= '0;
				addrDec[c] <= 1'b0;
				tc[c] <= 1'b0;
			end
			else
			begin
				// current reloads from the updated base word
				// a cpu write beats a transfer step on the same register
				if (addrLoad[c])
				begin
					baseAddr[c] <= newBase;
					curAddr[c] <= newBase;
				end
				else if (step[c])
					curAddr[c] <= addrDec[c] ? curAddr[c] - 1'b1 : curAddr[c] + 1'b1;
				// count write also re-arms the channel
				if (countLoad[c])
				begin
					baseCount[c] <= newBase;
					curCount[c] <= newBase;
					tc[c] <= 1'b0;
				end
				else if (step[c])
				begin
					curCount[c] <= curCount[c] - 1'b1;
					// terminal count when the count wraps past zero
					if (curCount[c] == '0)
						tc[c] <= 1'b1;
				end
				if (modeLoad[c])
				begin
					xferType[c] <= modeByte.xferType;
					addrDec[c] <= modeByte.addrDec;
				end
			end
		end
	end

	// channel view for the other blocks
	always_comb
	begin
		for (int c = 0; c < dmaRegPkg::numChannels; c++)
		begin
			chanState[c].curAddr = curAddr[c];
			chanState[c].curCount = curCount[c];
			chanState[c].xferType = xferType[c];
			chanState[c].tc = tc[c];
		end
	end

endmodule

/* hdl/dmaPriority.sv */
`timescale 1ns/1ps

module dmaPriority (
	input logic busIf,
	input logic rst,
	input logic [dmaRegPkg::numChannels-1:0] dreq,
	input dmaRegPkg::command_s command,
	input dmaRegPkg::chanState_s [dmaRegPkg::numChannels-1:0] chanState,
	input dmaBusPkg::xferDone_s xferDone,
	output logic [dmaRegPkg::numChannels-1:0] grant
);

	logic [dmaRegPkg::numChannels-1:0] eligible;
	// channel with the highest priority in rotating mode
	logic [dmaRegPkg::chanBits-1:0] rotPtr;
	logic [dmaRegPkg::chanBits-1:0] startChan;
	// search state
	logic [dmaRegPkg::chanBits-1:0] probe;
	logic found;

	// a request counts only before terminal count and with the controller on
	always_comb
	begin
		for (int c = 0; c < dmaRegPkg::numChannels; c++)
		begin
			eligible[c] = dreq[c] & ~chanState[c].tc & ~command.ctrlDisable;
		end
	end

	// served channel drops to lowest priority
	always_ff @(posedge busIf)
	begin
		if (rst)
			rotPtr <= '0;
		else if (xferDone.valid && command.rotatePriority)
			rotPtr <= xferDone.channel + 1'b1;
	end

	// fixed mode always starts the search at channel 0
	assign startChan = command.rotatePriority ? rotPtr : '0;

	// first eligible channel from the start point, wrapping mod 4
	always_comb
	begin
		grant = '0;
		found = 1'b0;
		probe = startChan;
		for (int i = 0; i < dmaRegPkg::numChannels; i++)
		begin
			if (!found && eligible[probe])
			begin
				grant[probe] = 1'b1;
				found = 1'b1;
			end
			probe = probe + 1'b1;
		end
	end

endmodule

/* hdl/dmaTimingControl.sv */
`timescale 1ns/1ps

module dmaTimingControl (
	input logic busIf,
	input logic rst,
	input logic hlda,
	input logic [dmaRegPkg::numChannels-1:0] grant,
	input dmaRegPkg::chanState_s [dmaRegPkg::numChannels-1:0] chanState,
	output dmaBusPkg::busCtrl_s busCtrl,
	output logic [dmaRegPkg::numChannels-1:0] dack,
	output logic [dmaRegPkg::addrWidth-1:0] addrOut,
	output dmaBusPkg::xferDone_s xferDone
);

	dmaBusPkg::dmaState_e state;
	dmaBusPkg::dmaState_e nextState;
	// channel being served and its encoded grant
	logic [dmaRegPkg::chanBits-1:0] activeChan;
	logic [dmaRegPkg::chanBits-1:0] grantChan;
	logic [1:0] activeType;

	// one-hot grant to index
	always_comb
	begin
		grantChan = '0;
		for (int c = 0; c < dmaRegPkg::numChannels; c++)
		begin
			if (grant[c])
				grantChan = c[dmaRegPkg::chanBits-1:0];
		end
	end

	// S0 waits for hlda, the rest of the transfer is fixed length
	always_comb
	begin
		unique case (state)
			dmaBusPkg::SI: nextState = (|grant) ? dmaBusPkg::S0 : dmaBusPkg::SI;
			dmaBusPkg::S0: nextState = hlda ? dmaBusPkg::S1 : dmaBusPkg::S0;
			dmaBusPkg::S1: nextState = dmaBusPkg::S2;
			dmaBusPkg::S2: nextState = dmaBusPkg::S4;
			dmaBusPkg::S4: nextState = dmaBusPkg::SI;
			default: nextState = dmaBusPkg::SI;
		endcase
	end

	// channel is held from the SI sample so a dropped dreq cannot move it
	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			state <= dmaBusPkg::SI;
			activeChan <= '0;
		end
		else
		begin
			state <= nextState;
			if ((state == dmaBusPkg::SI) && (|grant))
				activeChan <= grantChan;
		end
	end

	assign activeType = chanState[activeChan].xferType;

	// bus control decode
	always_comb
	begin
		busCtrl.iorN = 1'b1;
		busCtrl.iowN = 1'b1;
		busCtrl.memrN = 1'b1;
		busCtrl.memwN = 1'b1;
		busCtrl.hrq = (state != dmaBusPkg::SI);
		busCtrl.aen = (state == dmaBusPkg::S1) || (state == dmaBusPkg::S2);
		busCtrl.adstb = (state == dmaBusPkg::S1);
		if (state == dmaBusPkg::S2)
		begin
			// write to memory reads the device, read from memory writes it
			if (activeType == 2'b01)
			begin
				busCtrl.iorN = 1'b0;
				busCtrl.memwN = 1'b0;
			end
			else if (activeType == 2'b10)
			begin
				busCtrl.memrN = 1'b0;
				busCtrl.iowN = 1'b0;
			end
		end
	end

	// address and acknowledge
	always_comb
	begin
		addrOut = '0;
		dack = '0;
		if (busCtrl.aen)
			addrOut = chanState[activeChan].curAddr;
		if (state == dmaBusPkg::S2)
			dack[activeChan] = 1'b1;
	end

	// S4 closes the transfer, the channel steps at the following edge
	assign xferDone.valid = (state == dmaBusPkg::S4);
	assign xferDone.channel = activeChan;

endmodule

/* hdl/dmaTop.sv */
`timescale 1ns/1ps

module dmaTop (
	input logic busIf,
	input logic rst,
	input dmaBusPkg::cpuBus_s cpu,
	input logic [dmaRegPkg::numChannels-1:0] dreq,
	input logic hlda,
	output logic [dmaRegPkg::dataWidth-1:0] dbOut,
	output logic dbOutEn,
	output dmaBusPkg::busCtrl_s busCtrl,
	output logic [dmaRegPkg::numChannels-1:0] dack,
	output logic [dmaRegPkg::addrWidth-1:0] addrOut
);

	// shared channel view, command and strobes between blocks
	dmaRegPkg::chanState_s [dmaRegPkg::numChannels-1:0] chanState;
	dmaRegPkg::command_s command;
	dmaBusPkg::regWrite_s regWrite;
	dmaBusPkg::xferDone_s xferDone;
	logic [dmaRegPkg::numChannels-1:0] grant;

	// cpu program port
	dmaProgramPort programPort (
		.busIf(busIf),
		.rst(rst),
		.cpu(cpu),
		.dreq(dreq),
		.chanState(chanState),
		.command(command),
		.regWrite(regWrite),
		.dbOut(dbOut),
		.dbOutEn(dbOutEn)
	);

	// per-channel registers
	dmaChannelRegs channelRegs (
		.busIf(busIf),
		.rst(rst),
		.regWrite(regWrite),
		.xferDone(xferDone),
		.chanState(chanState)
	);

	// request arbitration
	dmaPriority priorityLogic (
		.busIf(busIf),
		.rst(rst),
		.dreq(dreq),
		.command(command),
		.chanState(chanState),
		.xferDone(xferDone),
		.grant(grant)
	);

	// transfer timing and bus strobes
	dmaTimingControl timingControl (
		.busIf(busIf),
		.rst(rst),
		.hlda(hlda),
		.grant(grant),
		.chanState(chanState),
		.busCtrl(busCtrl),
		.dack(dack),
		.addrOut(addrOut),
		.xferDone(xferDone)
	);

endmodule

/* bench/dmaTbTable.svh */
// row operations
typedef enum logic [2:0] {cpuWrite, cpuRead, setDreq, grantHlda, transfer} rowOp_e;

// one stimulus row
// transfer rows carry the served channel in port, the address shown in S1 in data
// and the S2 strobes {iorN, iowN, memrN, memwN} in expected
// grant rows carry the S0 wait before hlda in data and a pending request in expected
typedef struct packed {
	rowOp_e op;
	logic [3:0] port;
	logic [15:0] data;
	logic [15:0] expected;
} row_s;

row_s stimRows[$];

// reference model of the programmed channels
logic [15:0] mdlBaseAddr [4];
logic [15:0] mdlBaseCount [4];
logic [15:0] mdlAddr [4];
logic [15:0] mdlCount [4];
logic [1:0] mdlType [4];
logic [3:0] mdlDec;
logic [3:0] mdlTc;
logic [3:0] mdlDreq;
logic mdlPtr;
logic mdlRotate;
logic mdlDisable;
logic [1:0] mdlRotPtr;
logic [31:0] rngState;

// xorshift32 step
function automatic logic [31:0] xorshift();
	logic [31:0] x;
	x = rngState;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rngState = x;
	return x;
endfunction

task automatic pushRow(input rowOp_e op, input logic [3:0] port, input logic [15:0] data,
	input logic [15:0] expected);
	row_s row;
	row.op = op;
	row.port = port;
	row.data = data;
	row.expected = expected;
	stimRows.push_back(row);
endtask

// cpu write with the model following the register map
task automatic addWrite(input logic [3:0] port, input logic [7:0] data);
	int ch;
	ch = port[2:1];
	if (!port[3])
	begin
		// pointer picks the half and current reloads from base
		if (port[0])
		begin
			if (mdlPtr)
				mdlBaseCount[ch][15:8] = data;
			else
				mdlBaseCount[ch][7:0] = data;
			mdlCount[ch] = mdlBaseCount[ch];
			mdlTc[ch] = 1'b0;
		end
		else
		begin
			if (mdlPtr)
				mdlBaseAddr[ch][15:8] = data;
			else
				mdlBaseAddr[ch][7:0] = data;
			mdlAddr[ch] = mdlBaseAddr[ch];
		end
		mdlPtr = ~mdlPtr;
	end
	else if (port == dmaBusPkg::portCommand)
	begin
		mdlRotate = data[4];
		mdlDisable = data[2];
	end
	else if (port == dmaBusPkg::portMode)
	begin
		// mode byte names its own channel in bits 1:0
		mdlType[data[1:0]] = data[3:2];
		mdlDec[data[1:0]] = data[5];
	end
	else if (port == dmaBusPkg::portClearFF)
		mdlPtr = 1'b0;
	pushRow(cpuWrite, port, {8'h00, data}, 16'h0000);
endtask

// cpu read with the expected byte from the model
task automatic addRead(input logic [3:0] port);
	logic [15:0] word;
	logic [7:0] val;
	val = 8'h00;
	if (!port[3])
	begin
		word = port[0] ? mdlCount[port[2:1]] : mdlAddr[port[2:1]];
		val = mdlPtr ? word[15:8] : word[7:0];
		mdlPtr = ~mdlPtr;
	end
	else if (port == dmaBusPkg::portCommand)
		val = {mdlDreq, mdlTc};
	pushRow(cpuRead, port, 16'h0000, {8'h00, val});
endtask

// low byte first, high byte second
task automatic addWord(input logic [3:0] port, input logic [15:0] value);
	addWrite(port, value[7:0]);
	addWrite(port, value[15:8]);
endtask

task automatic addDreq(input logic [3:0] pattern);
	mdlDreq = pattern;
	pushRow(setDreq, 4'h0, {12'h000, pattern}, 16'h0000);
endtask

// one transfer for the winner, or a no-request check when nothing is eligible
task automatic addTransfer();
	logic [3:0] elig;
	logic [15:0] strobes;
	logic [15:0] hold;
	int start;
	int ch;
	int idx;
	elig = mdlDisable ? 4'h0 : (mdlDreq & ~mdlTc);
	start = mdlRotate ? int'(mdlRotPtr) : 0;
	ch = -1;
	for (int i = 0; i < 4; i++)
	begin
		idx = (start + i) % 4;
		if (ch < 0 && elig[idx])
			ch = idx;
	end
	if (ch < 0)
		pushRow(grantHlda, 4'h0, 16'h0000, 16'h0000);
	else
	begin
		// write to memory 0110, read from memory 1001, verify none
		case (mdlType[ch])
			2'b01: strobes = 16'h0006;
			2'b10: strobes = 16'h0009;
			default: strobes = 16'h000f;
		endcase
		// S0 lasts 0 to 3 extra cycles before hlda arrives
		hold = 16'(xorshift() % 32'd4);
		pushRow(grantHlda, 4'h0, hold, 16'h0001);
		pushRow(transfer, 4'(ch), mdlAddr[ch], strobes);
		mdlAddr[ch] = mdlDec[ch] ? mdlAddr[ch] - 16'd1 : mdlAddr[ch] + 16'd1;
		// count wrapping past zero marks terminal count
		if (mdlCount[ch] == 16'h0000)
			mdlTc[ch] = 1'b1;
		mdlCount[ch] = mdlCount[ch] - 16'd1;
		if (mdlRotate)
			mdlRotPtr = 2'(ch + 1);
	end
endtask

task automatic buildTable();
	logic [31:0] rnd;
	logic [1:0] chanType [4];
	int k;
	rngState = 32'd2421;
	chanType = '{2'b01, 2'b10, 2'b00, 2'b01};
	for (int c = 0; c < 4; c++)
	begin
		mdlBaseAddr[c] = 16'h0000;
		mdlBaseCount[c] = 16'h0000;
		mdlAddr[c] = 16'h0000;
		mdlCount[c] = 16'h0000;
		mdlType[c] = 2'b00;
	end
	mdlDec = 4'h0;
	mdlTc = 4'h0;
	mdlDreq = 4'h0;
	mdlPtr = 1'b0;
	mdlRotate = 1'b0;
	mdlDisable = 1'b0;
	mdlRotPtr = 2'd0;
	// program every channel with counts kept large so no channel ends early
	for (int c = 0; c < 4; c++)
	begin
		rnd = xorshift();
		if (c == 1)
		begin
			// stray low byte and then the pair restarts
			addWrite(4'(2 * c), rnd[31:24]);
			addWrite(dmaBusPkg::portClearFF, 8'h00);
		end
		addWord(4'(2 * c), rnd[15:0]);
		addWord(4'(2 * c + 1), {rnd[23:16] | 8'h01, rnd[31:24]});
		// channels 1 and 3 count the address down
		addWrite(dmaBusPkg::portMode, {2'b01, c[0], 1'b0, chanType[c], 2'(c)});
	end
	for (int p = 0; p < 8; p++)
	begin
		addRead(4'(p));
		addRead(4'(p));
	end
	// fixed priority over random request patterns
	repeat (12)
	begin
		rnd = xorshift();
		addDreq(rnd[3:0]);
		addTransfer();
	end
	addDreq(4'h0);
	// disabled controller leaves every request waiting
	addWrite(dmaBusPkg::portCommand, 8'h04);
	addDreq(4'hf);
	addTransfer();
	addDreq(4'h0);
	// rotating priority with all requests held
	addWrite(dmaBusPkg::portCommand, 8'h10);
	addDreq(4'hf);
	repeat (5)
		addTransfer();
	addDreq(4'h0);
	addWrite(dmaBusPkg::portCommand, 8'h00);
	// terminal count on channel 2 after k+1 transfers
	rnd = xorshift();
	k = int'(rnd % 3) + 1;
	addWord(4'd5, 16'(k));
	addDreq(4'b0100);
	repeat (k + 2)
		addTransfer();
	addRead(dmaBusPkg::portCommand);
	addDreq(4'h0);
	addWord(4'd5, 16'(k));
	addRead(dmaBusPkg::portCommand);
	addDreq(4'b0100);
	addTransfer();
	addDreq(4'h0);
	// stepped addresses and counts
	for (int p = 0; p < 8; p++)
	begin
		addRead(4'(p));
		addRead(4'(p));
	end
endtask

/* bench/dmaTb.sv */
`timescale 1ns/1ps

module dmaTb;

	logic busIf;
	logic rst;
	dmaBusPkg::cpuBus_s cpu;
	logic [3:0] dreq;
	logic hlda;
	logic [7:0] dbOut;
	logic dbOutEn;
	dmaBusPkg::busCtrl_s busCtrl;
	logic [3:0] dack;
	logic [15:0] addrOut;
	int checkCount;
	bit tableReady;

	`include "dmaTbTable.svh"

	dmaTop uut (
		.busIf(busIf),
		.rst(rst),
		.cpu(cpu),
		.dreq(dreq),
		.hlda(hlda),
		.dbOut(dbOut),
		.dbOutEn(dbOutEn),
		.busCtrl(busCtrl),
		.dack(dack),
		.addrOut(addrOut)
	);

	// 4 ns clock
	always #2 busIf = ~busIf;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped on the first failure");
	endtask

	task automatic compareHex(input string name, input logic [15:0] expected,
		input logic [15:0] got);
		checkCount++;
		if (got !== expected)
			failRun($sformatf("Error %s expected 0x%h got 0x%h", name, expected, got));
	endtask

	// inputs move and outputs are read 1 ns after the edge
	task automatic nextCycle();
		@(posedge busIf);
		#1;
	endtask

	task automatic releaseCpu();
		cpu.csN = 1'b1;
		cpu.iorN = 1'b1;
		cpu.iowN = 1'b1;
		cpu.addr = 4'h0;
		cpu.dbIn = 8'h00;
	endtask

	task automatic applyWrite(input logic [3:0] port, input logic [7:0] data);
		cpu.csN = 1'b0;
		cpu.iowN = 1'b0;
		cpu.addr = port;
		cpu.dbIn = data;
		nextCycle();
		releaseCpu();
	endtask

	// buffer drives for the one cycle after the read
	task automatic applyRead(input logic [3:0] port, input logic [7:0] expected);
		cpu.csN = 1'b0;
		cpu.iorN = 1'b0;
		cpu.addr = port;
		nextCycle();
		compareHex("dbOutEn", 16'h1, 16'(dbOutEn));
		compareHex("dbOut", 16'(expected), 16'(dbOut));
		releaseCpu();
		nextCycle();
		compareHex("dbOutEn", 16'h0, 16'(dbOutEn));
	endtask

	task automatic awaitGrant(input logic wanted, input int hold);
		int waited;
		waited = 0;
		if (wanted)
		begin
			while (!busCtrl.hrq && waited < 8)
			begin
				nextCycle();
				waited++;
			end
			if (!busCtrl.hrq)
				failRun("hrq did not rise for a pending request");
			else
			begin
				// S0 holds the bus request only
				compareHex("aen", 16'h0, 16'(busCtrl.aen));
				// and keeps holding it while hlda stays low
				repeat (hold)
				begin
					nextCycle();
					compareHex("hrq", 16'h1, 16'(busCtrl.hrq));
					compareHex("aen", 16'h0, 16'(busCtrl.aen));
				end
				hlda = 1'b1;
			end
		end
		else
		begin
			repeat (6)
			begin
				nextCycle();
				compareHex("hrq", 16'h0, 16'(busCtrl.hrq));
			end
		end
	endtask

	// S1, S2 and S4 follow hlda and then the bus goes back
	task automatic runTransfer(input row_s row);
		logic [15:0] ackWanted;
		ackWanted = 16'h0001 << row.port;
		nextCycle();
		compareHex("aen", 16'h1, 16'(busCtrl.aen));
		compareHex("adstb", 16'h1, 16'(busCtrl.adstb));
		compareHex("addrOut", row.data, addrOut);
		compareHex("dack", 16'h0, 16'(dack));
		nextCycle();
		compareHex("aen", 16'h1, 16'(busCtrl.aen));
		compareHex("adstb", 16'h0, 16'(busCtrl.adstb));
		compareHex("addrOut", row.data, addrOut);
		compareHex("dack", ackWanted, 16'(dack));
		compareHex("strobes", row.expected,
			16'({busCtrl.iorN, busCtrl.iowN, busCtrl.memrN, busCtrl.memwN}));
		nextCycle();
		compareHex("aen", 16'h0, 16'(busCtrl.aen));
		compareHex("adstb", 16'h0, 16'(busCtrl.adstb));
		compareHex("dack", 16'h0, 16'(dack));
		compareHex("hrq", 16'h1, 16'(busCtrl.hrq));
		compareHex("strobes", 16'h000f,
			16'({busCtrl.iorN, busCtrl.iowN, busCtrl.memrN, busCtrl.memwN}));
		nextCycle();
		compareHex("hrq", 16'h0, 16'(busCtrl.hrq));
		hlda = 1'b0;
	endtask

	task automatic applyRow(input row_s row);
		case (row.op)
			cpuWrite: applyWrite(row.port, row.data[7:0]);
			cpuRead: applyRead(row.port, row.expected[7:0]);
			// no cycle used so the next SI sample sees the new pattern
			setDreq: dreq = row.data[3:0];
			grantHlda: awaitGrant(row.expected[0], int'(row.data));
			transfer: runTransfer(row);
		endcase
	endtask

	// watchdog sized from the table
	initial
	begin
		wait (tableReady);
		#((stimRows.size() * 20 + 8) * 4);
		failRun("watchdog expired before the stimulus table was finished");
	end

	initial
	begin
		busIf = 1'b0;
		rst = 1'b1;
		dreq = 4'h0;
		hlda = 1'b0;
		checkCount = 0;
		releaseCpu();
		buildTable();
		tableReady = 1'b1;
		repeat (8) @(posedge busIf);
		#1;
		rst = 1'b0;
		// reset state has strobes high and aen, adstb, hrq low
		compareHex("busCtrl", 16'h0078, 16'(busCtrl));
		compareHex("dack", 16'h0, 16'(dack));
		compareHex("dbOutEn", 16'h0, 16'(dbOutEn));
		foreach (stimRows[r])
			applyRow(stimRows[r]);
		if (checkCount > 0)
		begin
			$display("TEST OK");
			$finish;
		end
		else
			failRun("no checks were run");
	end

endmodule

/* files.f */
+incdir+bench
hdl/dmaRegPkg.sv
hdl/dmaBusPkg.sv
hdl/dmaProgramPort.sv
hdl/dmaChannelRegs.sv
hdl/dmaPriority.sv
hdl/dmaTimingControl.sv
hdl/dmaTop.sv
bench/dmaTb.sv

/* Makefile */
# Verilator build and run of the DMA controller testbench

VERILATOR ?= verilator
TOP ?= dmaTb
FILELIST ?= files.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# a failing run ends in $$fatal, which makes the binary exit non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
